/* hdl/lane_join_pkg.sv */
// Shared definitions for the two-lane stream joiner and its APB control port
package lane_join_pkg;

  // Width of the APB address bus, byte addressed
  localparam int unsigned ApbAddrWidth = 12;

  // Width of the APB data bus
  localparam int unsigned ApbDataWidth = 32;

  // Operation register, the low two bits select the join operation
  localparam logic [ApbAddrWidth-1:0] REG_OP_OFFSET    = 'h0;

  // Writing bit 0 empties both lanes and the output stage in one cycle
  localparam logic [ApbAddrWidth-1:0] REG_FLUSH_OFFSET = 'h4;

  // Read-only count of pairs joined since reset, wraps at 32 bits
  localparam logic [ApbAddrWidth-1:0] REG_COUNT_OFFSET = 'h8;

  // Operation applied to every pair of lane heads
  // All results wrap at the data width of the lanes
  // OP_MAX compares both operands as unsigned numbers
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_XOR = 2'b10,
    OP_MAX = 2'b11
  } join_op_e;

endpackage

/* hdl/spill_register_flushable.sv */
`timescale 1ns/1ps

// Two-entry register slice between a valid/ready source and sink
// No combinational path runs from the input handshake to the output handshake
// A flush empties both entries in a single cycle
module spill_register_flushable #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  logic                 flush_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o
);

  // Entry A always takes new items from the upstream side
  logic [DataWidth-1:0] a_data_q;
  logic                 a_full_q;
  logic                 a_fill;
  logic                 a_drain;

  // Entry B parks the older item while the downstream side stalls
  logic [DataWidth-1:0] b_data_q;
  logic                 b_full_q;
  logic                 b_fill;
  logic                 b_drain;

  // An item is taken whenever there is room and no flush is in progress
  // Sources keep valid_i low during a flush, otherwise the item is dropped
  assign a_fill = valid_i && ready_o && !flush_i;

  // A gives up its item when B is free to act as the head
  // The item then leaves either to the sink or into B
  assign a_drain = (a_full_q && !b_full_q) || flush_i;

  // B only catches A's item if the sink refuses it in the same cycle
  assign b_fill = a_drain && !ready_i && !flush_i;

  // B empties on a sink transfer or on a flush
  assign b_drain = (b_full_q && ready_i) || flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  // Payload entries are only read while their full flag is set
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Room is left as long as one entry is free, so ready depends on state only
  assign ready_o = !a_full_q || !b_full_q;

  // Either entry holds a valid head
  assign valid_o = a_full_q || b_full_q;

  // B always holds the older item when both are full, which keeps the order
  assign data_o = b_full_q ? b_data_q : a_data_q;

endmodule

/* hdl/lane_combiner.sv */
`timescale 1ns/1ps

// Pairs the heads of lane A and lane B in arrival order
// Each pair is reduced to one result by the selected operation
// The result waits in a one-entry registered output stage
module lane_combiner import lane_join_pkg::*; #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  join_op_e             op_i,
  input  logic                 a_valid_i,
  output logic                 a_ready_o,
  input  logic [DataWidth-1:0] a_data_i,
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  input  logic [DataWidth-1:0] b_data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] out_data_o,
  output logic                 join_fire_o
);

  logic                 out_valid_q;
  logic [DataWidth-1:0] out_data_q;
  logic                 out_free;
  logic                 fire;
  logic [DataWidth-1:0] result;

  // The output stage can take a new result when empty or drained this cycle
  assign out_free = !out_valid_q || out_ready_i;

  // A lane is only popped when its partner is present too
  // Both lane valids come from registers, so no loop forms here
  assign a_ready_o = b_valid_i && out_free && !flush_i;
  assign b_ready_o = a_valid_i && out_free && !flush_i;

  // Both heads leave together in the same cycle
  assign fire = a_valid_i && a_ready_o;
  assign join_fire_o = fire;

  // Arithmetic wraps at the data width by construction
  always_comb begin
    result = a_data_i + b_data_i;
    case (op_i)
      OP_ADD: result = a_data_i + b_data_i;
      OP_SUB: result = a_data_i - b_data_i;
      OP_XOR: result = a_data_i ^ b_data_i;
      OP_MAX: result = (a_data_i > b_data_i) ? a_data_i : b_data_i;
      default: result = a_data_i + b_data_i;
    endcase
  end

  // A flush discards a result that has not been taken yet
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      out_valid_q <= 1'b0;
    end else if (fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      out_data_q <= result;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

/* hdl/apb_lane_csr.sv */
`timescale 1ns/1ps

// APB register block of the joiner
// Holds the operation select, issues the flush pulse and counts joined pairs
// Every access completes in its access phase without wait states
module apb_lane_csr import lane_join_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [ApbAddrWidth-1:0] paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [ApbDataWidth-1:0] pwdata_i,
  output logic [ApbDataWidth-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output join_op_e                op_o,
  output logic                    flush_o,
  input  logic                    join_fire_i
);

  logic                    access;
  logic                    wr_access;
  logic                    rd_access;
  logic                    hit_op;
  logic                    hit_flush;
  logic                    hit_count;
  logic                    mapped;
  join_op_e                op_q;
  logic [ApbDataWidth-1:0] count_q;

  // The access phase is the second cycle of a transfer
  assign access    = psel_i && penable_i;
  assign wr_access = access && pwrite_i;
  assign rd_access = access && !pwrite_i;

  // Full address compare, aliases are treated as unmapped
  assign hit_op    = (paddr_i == REG_OP_OFFSET);
  assign hit_flush = (paddr_i == REG_FLUSH_OFFSET);
  assign hit_count = (paddr_i == REG_COUNT_OFFSET);
  assign mapped    = hit_op || hit_flush || hit_count;

  // No wait states are ever inserted
  assign pready_o = 1'b1;

  // Unmapped offsets fail in the access phase and leave all state untouched
  assign pslverr_o = access && !mapped;

  // Only the low two bits of a write carry the operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= OP_ADD;
    end else if (wr_access && hit_op) begin
      op_q <= join_op_e'(pwdata_i[1:0]);
    end
  end

  assign op_o = op_q;

  // Flush lasts exactly the access cycle of the write
  // The lanes and the output stage see it at the same edge
  assign flush_o = wr_access && hit_flush && pwdata_i[0];

  // Count of pairs taken by the combiner since reset
  // A flush leaves it alone, it wraps silently on overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (join_fire_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Writes to the count offset are accepted and ignored

  // Read data is returned combinationally during the access phase
  // The flush register always reads as zero
  always_comb begin
    prdata_o = '0;
    if (rd_access) begin
      if (hit_op) begin
        prdata_o = {{(ApbDataWidth-2){1'b0}}, op_q};
      end else if (hit_count) begin
        prdata_o = count_q;
      end
    end
  end

endmodule

/* hdl/lane_join_top.sv */
`timescale 1ns/1ps

// Two-lane stream joiner with APB control
// Each lane passes through its own spill register before the combiner
// The register block selects the operation and flushes the datapath
module lane_join_top import lane_join_pkg::*; #(
  parameter int unsigned DataWidth = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Lane A input stream
  input  logic                    a_valid_i,
  output logic                    a_ready_o,
  input  logic [DataWidth-1:0]    a_data_i,
  // Lane B input stream
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  input  logic [DataWidth-1:0]    b_data_i,
  // Joined output stream
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [DataWidth-1:0]    out_data_o,
  // APB control port
  input  logic [ApbAddrWidth-1:0] paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [ApbDataWidth-1:0] pwdata_i,
  output logic [ApbDataWidth-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  // Lane heads as seen by the combiner
  logic                 lane_a_valid;
  logic                 lane_a_ready;
  logic [DataWidth-1:0] lane_a_data;
  logic                 lane_b_valid;
  logic                 lane_b_ready;
  logic [DataWidth-1:0] lane_b_data;

  // Control between the register block and the datapath
  join_op_e             op;
  logic                 flush;
  logic                 join_fire;

  spill_register_flushable #(
    .DataWidth(DataWidth)
  ) i_lane_a (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(a_valid_i),
    .flush_i(flush),
    .ready_o(a_ready_o),
    .data_i (a_data_i),
    .valid_o(lane_a_valid),
    .ready_i(lane_a_ready),
    .data_o (lane_a_data)
  );

  spill_register_flushable #(
    .DataWidth(DataWidth)
  ) i_lane_b (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(b_valid_i),
    .flush_i(flush),
    .ready_o(b_ready_o),
    .data_i (b_data_i),
    .valid_o(lane_b_valid),
    .ready_i(lane_b_ready),
    .data_o (lane_b_data)
  );

  lane_combiner #(
    .DataWidth(DataWidth)
  ) i_combiner (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush),
    .op_i       (op),
    .a_valid_i  (lane_a_valid),
    .a_ready_o  (lane_a_ready),
    .a_data_i   (lane_a_data),
    .b_valid_i  (lane_b_valid),
    .b_ready_o  (lane_b_ready),
    .b_data_i   (lane_b_data),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_data_o (out_data_o),
    .join_fire_o(join_fire)
  );

  apb_lane_csr i_csr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .op_o       (op),
    .flush_o    (flush),
    .join_fire_i(join_fire)
  );

endmodule

/* tests/lane_join_assertions.sv */
`timescale 1ns/1ps

// Protocol checks on the joiner top level
// Bound into lane_join_top so they see the internal flush pulse as well
module lane_join_assertions #(
  parameter int unsigned DataWidth = 16
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 a_valid_i,
  input logic                 a_ready_o,
  input logic [DataWidth-1:0] a_data_i,
  input logic                 b_valid_i,
  input logic                 b_ready_o,
  input logic [DataWidth-1:0] b_data_i,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic [DataWidth-1:0] out_data_o,
  input logic                 pready_o,
  input logic                 flush_i
);

  // Sources keep both lanes quiet while a flush empties the datapath
  no_valid_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> (!a_valid_i && !b_valid_i))
    else $error("Lane valid is high during a flush cycle");

  // A stalled lane item stays put until the joiner accepts it
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (a_valid_i && !a_ready_o) |=> (a_valid_i && $stable(a_data_i)))
    else $error("Lane A dropped or changed an item under stall");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_valid_i && !b_ready_o) |=> (b_valid_i && $stable(b_data_i)))
    else $error("Lane B dropped or changed an item under stall");

  // Only a flush may withdraw a stalled result
  out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(out_data_o)))
    else $error("Output result dropped or changed under stall");

  // The output stage comes out of reset empty
  out_idle_after_reset: assert property (@(posedge clk_i)
    !rst_ni |=> !out_valid_o)
    else $error("Output valid is high right after reset");

  // The register block never inserts wait states
  no_wait_states: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_o)
    else $error("APB ready is low");

endmodule

bind lane_join_top lane_join_assertions #(
  .DataWidth(DataWidth)
) i_lane_join_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .a_valid_i  (a_valid_i),
  .a_ready_o  (a_ready_o),
  .a_data_i   (a_data_i),
  .b_valid_i  (b_valid_i),
  .b_ready_o  (b_ready_o),
  .b_data_i   (b_data_i),
  .out_valid_o(out_valid_o),
  .out_ready_i(out_ready_i),
  .out_data_o (out_data_o),
  .pready_o   (pready_o),
  .flush_i    (flush)
);

/* tests/tb_lane_join.sv */
`timescale 1ns/1ps

// Self-checking testbench for the two-lane stream joiner
// Random lane traffic is mirrored into per-lane queues and paired in order
module tb_lane_join import lane_join_pkg::*; ();

  localparam int unsigned DataWidth     = 16;
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned Seed          = 32'hf18d_3c9f;
  localparam int unsigned ItemsPerOp    = 40;
  localparam int unsigned UnevenItems   = 30;
  localparam int unsigned StallItems    = 10;
  localparam int unsigned FlushItems    = 3;
  // Items per lane over the whole run including the post-flush stream
  localparam int unsigned TotalItems    = 5 * ItemsPerOp + 2 * UnevenItems + StallItems
                                          + FlushItems;
  localparam int unsigned CyclesPerItem = 40;
  localparam int unsigned TimeoutNs     = (TotalItems * CyclesPerItem + 200) * ClkPeriod;

  logic                    clk;
  logic                    rst_n;
  logic                    a_valid;
  logic                    a_ready;
  logic [DataWidth-1:0]    a_data;
  logic                    b_valid;
  logic                    b_ready;
  logic [DataWidth-1:0]    b_data;
  logic                    out_valid;
  logic                    out_ready;
  logic [DataWidth-1:0]    out_data;
  logic [ApbAddrWidth-1:0] paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbDataWidth-1:0] pwdata;
  logic [ApbDataWidth-1:0] prdata;
  logic                    pready;
  logic                    pslverr;

  // Reference model state where items wait until their pair leaves the DUT
  logic [DataWidth-1:0] qa[$];
  logic [DataWidth-1:0] qb[$];
  join_op_e             cur_op;
  int unsigned          a_left;
  int unsigned          b_left;
  int unsigned          n_out;
  int unsigned          n_flushed;
  bit                   a_taken;
  bit                   b_taken;

  always #(ClkPeriod / 2) clk = ~clk;

  lane_join_top dut0 (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .a_valid_i  (a_valid),
    .a_ready_o  (a_ready),
    .a_data_i   (a_data),
    .b_valid_i  (b_valid),
    .b_ready_o  (b_ready),
    .b_data_i   (b_data),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .out_data_o (out_data),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr)
  );

  // Result of one pair where every operation wraps at the lane width
  function automatic logic [DataWidth-1:0] expected_result(join_op_e op,
                                                           logic [DataWidth-1:0] a,
                                                           logic [DataWidth-1:0] b);
    case (op)
      OP_ADD: return a + b;
      OP_SUB: return a - b;
      OP_XOR: return a ^ b;
      default: return (a >= b) ? a : b;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp) else begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("Check failed: %s", what);
      $display("STATUS: FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  // One clock of lane traffic with probabilities given in percent
  // A pending item keeps its valid and data until it is accepted
  task automatic lane_cycle(int pa, int pb, int pr);
    logic [DataWidth-1:0] ea;
    logic [DataWidth-1:0] eb;
    @(negedge clk);
    if (!a_valid || a_taken) begin
      a_valid = (a_left > 0) && (($urandom % 100) < pa);
      a_data  = DataWidth'($urandom);
    end
    if (!b_valid || b_taken) begin
      b_valid = (b_left > 0) && (($urandom % 100) < pb);
      b_data  = DataWidth'($urandom);
    end
    out_ready = ($urandom % 100) < pr;
    // Readies and the output stage are registered, so they hold until the next edge
    #1;
    a_taken = a_valid && a_ready;
    b_taken = b_valid && b_ready;
    // A result leaving now can only hold items taken in earlier cycles
    if (out_valid && out_ready) begin
      check_true(qa.size() > 0 && qb.size() > 0, "output appeared without a lane partner");
      ea = qa.pop_front();
      eb = qb.pop_front();
      check_value("out_data_o", 32'(out_data), 32'(expected_result(cur_op, ea, eb)));
      n_out++;
    end
    if (a_taken) begin
      qa.push_back(a_data);
      a_left--;
    end
    if (b_taken) begin
      qb.push_back(b_data);
      b_left--;
    end
  endtask

  function automatic bit stream_done();
    return !a_valid && !b_valid && a_left == 0 && b_left == 0 && qa.size() == 0
           && qb.size() == 0;
  endfunction

  // Sends n items on each lane and waits until every pair has left the DUT
  task automatic run_stream(int unsigned n, int pa, int pb, int pr);
    a_left = n;
    b_left = n;
    do begin
      lane_cycle(pa, pb, pr);
    end while (!stream_done());
  endtask

  // Setup phase followed by an access phase that always completes at once
  task automatic apb_access(logic [ApbAddrWidth-1:0] addr, bit write,
                            logic [ApbDataWidth-1:0] wdata,
                            output logic [ApbDataWidth-1:0] rdata, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_value("pready_o", 32'(pready), 32'h1);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(logic [ApbAddrWidth-1:0] addr, logic [ApbDataWidth-1:0] wdata);
    logic [ApbDataWidth-1:0] unused_rdata;
    logic                    err;
    apb_access(addr, 1'b1, wdata, unused_rdata, err);
    check_value("pslverr_o", 32'(err), 32'h0);
  endtask

  task automatic read_reg(logic [ApbAddrWidth-1:0] addr, output logic [ApbDataWidth-1:0] rdata);
    logic err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check_value("pslverr_o", 32'(err), 32'h0);
  endtask

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [ApbDataWidth-1:0] rdata;
    logic                    err;
    int unsigned             flushed;
    void'($urandom(Seed));
    clk       = 1'b0;
    rst_n     = 1'b0;
    a_valid   = 1'b0;
    a_data    = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    out_ready = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    cur_op    = OP_ADD;
    a_left    = 0;
    b_left    = 0;
    n_out     = 0;
    n_flushed = 0;
    a_taken   = 1'b0;
    b_taken   = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset values of the registers and the handshakes
    read_reg(REG_OP_OFFSET, rdata);
    check_value("prdata_o", rdata, 32'(OP_ADD));
    read_reg(REG_COUNT_OFFSET, rdata);
    check_value("prdata_o", rdata, 32'h0);
    check_value("out_valid_o", 32'(out_valid), 32'h0);
    check_value("a_ready_o", 32'(a_ready), 32'h1);
    check_value("b_ready_o", 32'(b_ready), 32'h1);

    // Every operation under random traffic and random output stalls
    for (int i = 0; i < 4; i++) begin
      cur_op = join_op_e'(i[1:0]);
      write_reg(REG_OP_OFFSET, 32'(i));
      read_reg(REG_OP_OFFSET, rdata);
      check_value("prdata_o", rdata, 32'(cur_op));
      run_stream(ItemsPerOp, 70, 70, 60);
    end

    // One lane runs ahead in bursts while the other lags, then the reverse
    run_stream(UnevenItems, 95, 15, 70);
    run_stream(UnevenItems, 15, 95, 70);

    // Two entries per lane plus one pair in the output stage fill the joiner
    a_left = StallItems;
    b_left = StallItems;
    do begin
      lane_cycle(100, 100, 0);
    end while (a_ready || b_ready);
    check_value("accepted lane A items", 32'(qa.size()), 32'h3);
    check_value("accepted lane B items", 32'(qb.size()), 32'h3);
    do begin
      lane_cycle(100, 100, 100);
    end while (!stream_done());

    // Load the joiner with the output stalled and go quiet before the flush
    a_left = FlushItems;
    b_left = FlushItems;
    do begin
      lane_cycle(100, 100, 0);
    end while (a_left > 0 || b_left > 0 || a_valid || b_valid);
    repeat (3) lane_cycle(0, 0, 0);
    flushed = (qa.size() > 0 && qb.size() > 0) ? 1 : 0;
    check_value("out_valid_o", 32'(out_valid), 32'(flushed));
    write_reg(REG_FLUSH_OFFSET, 32'h1);
    check_value("out_valid_o", 32'(out_valid), 32'h0);
    check_value("a_ready_o", 32'(a_ready), 32'h1);
    check_value("b_ready_o", 32'(b_ready), 32'h1);
    qa.delete();
    qb.delete();
    n_flushed += flushed;
    run_stream(ItemsPerOp, 70, 70, 60);

    // The join count survives the flush
    read_reg(REG_COUNT_OFFSET, rdata);
    check_value("prdata_o", rdata, n_out + n_flushed);
    // Unmapped offsets fail without side effects
    apb_access(12'h010, 1'b0, '0, rdata, err);
    check_value("pslverr_o", 32'(err), 32'h1);
    apb_access(12'h00c, 1'b1, 32'h0000_0001, rdata, err);
    check_value("pslverr_o", 32'(err), 32'h1);
    read_reg(REG_OP_OFFSET, rdata);
    check_value("prdata_o", rdata, 32'(cur_op));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* flist.f */
hdl/lane_join_pkg.sv
hdl/spill_register_flushable.sv
hdl/lane_combiner.sv
hdl/apb_lane_csr.sv
hdl/lane_join_top.sv
tests/lane_join_assertions.sv
tests/tb_lane_join.sv

/* Makefile */
# Verilator build for the two-lane stream joiner
# A failing run ends in $fatal, so the simulator exit status carries the result

VERILATOR ?= verilator
TOP       ?= tb_lane_join
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
